//--- include/ex_params.svh
/* Width and count macros for the execute stage, RV32 only.
   EX_FU_IDX_W must be wide enough to hold EX_NUM_ALU */
`ifndef EX_PARAMS_SVH
`define EX_PARAMS_SVH

// Datapath
`define EX_XLEN       32
`define EX_SHAMT_W    5

// Functional units
`define EX_NUM_ALU    3
`define EX_FU_IDX_W   2

// Tags carried along with each instruction
`define EX_REG_IDX_W  5
`define EX_ROB_IDX_W  4

`endif

//--- hdl/ex_pkg.sv
/* Shared enums of the execute stage.
   Branch condition codes follow funct3 of the RV32 branch opcodes */
package ex_pkg;

    // ALU operations
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLT  = 4'd2,
        ALU_SLTU = 4'd3,
        ALU_AND  = 4'd4,
        ALU_OR   = 4'd5,
        ALU_XOR  = 4'd6,
        ALU_SLL  = 4'd7,
        ALU_SRL  = 4'd8,
        ALU_SRA  = 4'd9
    } alu_func_e;

    typedef enum logic [1:0] {
        OPA_RS1  = 2'd0,
        OPA_NPC  = 2'd1,
        OPA_PC   = 2'd2,
        OPA_ZERO = 2'd3
    } opa_sel_e;

    typedef enum logic [2:0] {
        OPB_RS2   = 3'd0,
        OPB_I_IMM = 3'd1,
        OPB_S_IMM = 3'd2,
        OPB_B_IMM = 3'd3,
        OPB_U_IMM = 3'd4,
        OPB_J_IMM = 3'd5
    } opb_sel_e;

    typedef enum logic {
        FU_ALU    = 1'b0,
        FU_BRANCH = 1'b1
    } fu_type_e;

    // funct3 of BRANCH, 3'b011 also maps to never
    typedef enum logic [2:0] {
        COND_EQ    = 3'b000,
        COND_NE    = 3'b001,
        COND_NEVER = 3'b010,
        COND_LT    = 3'b100,
        COND_GE    = 3'b101,
        COND_LTU   = 3'b110,
        COND_GEU   = 3'b111
    } branch_cond_e;

endpackage

//--- hdl/ex_operand_select.sv
/* Purely combinational operand and start decode.
   An ALU index at or above EX_NUM_ALU starts no unit */
`timescale 1ns/1ns
`include "ex_params.svh"

module ex_operand_select (
    input  logic                     issue_valid,
    input  ex_pkg::fu_type_e         issue_fu_type,
    input  logic [`EX_FU_IDX_W-1:0]  issue_fu_index,
    input  ex_pkg::opa_sel_e         opa_select,
    input  ex_pkg::opb_sel_e         opb_select,
    input  logic [31:0]              inst,
    input  logic [`EX_XLEN-1:0]      pc,
    input  logic [`EX_XLEN-1:0]      npc,
    input  logic [`EX_XLEN-1:0]      rs1_value,
    input  logic [`EX_XLEN-1:0]      rs2_value,
    output logic [`EX_XLEN-1:0]      opa,
    output logic [`EX_XLEN-1:0]      opb,
    output ex_pkg::branch_cond_e     branch_cond,
    output logic [`EX_NUM_ALU-1:0]   alu_start,
    output logic                     branch_start
);

    logic [`EX_XLEN-1:0] i_imm;
    logic [`EX_XLEN-1:0] s_imm;
    logic [`EX_XLEN-1:0] b_imm;
    logic [`EX_XLEN-1:0] u_imm;
    logic [`EX_XLEN-1:0] j_imm;

    ////////////////////
    // Immediates
    ////////////////////
    assign i_imm = {{20{inst[31]}}, inst[31:20]};
    assign s_imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign b_imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    assign u_imm = {inst[31:12], 12'b0};
    assign j_imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

    ////////////////////
    // Operand muxes
    ////////////////////
    always_comb begin
        case (opa_select)
            ex_pkg::OPA_RS1: opa = rs1_value;
            ex_pkg::OPA_NPC: opa = npc;
            ex_pkg::OPA_PC:  opa = pc;
            default:         opa = '0;  // OPA_ZERO
        endcase
    end

    always_comb begin
        case (opb_select)
            ex_pkg::OPB_RS2:   opb = rs2_value;
            ex_pkg::OPB_I_IMM: opb = i_imm;
            ex_pkg::OPB_S_IMM: opb = s_imm;
            ex_pkg::OPB_B_IMM: opb = b_imm;
            ex_pkg::OPB_U_IMM: opb = u_imm;
            ex_pkg::OPB_J_IMM: opb = j_imm;
            default:           opb = '0;  // Unused encodings
        endcase
    end

    // funct3 decode, the two reserved codes never branch
    always_comb begin
        case (inst[14:12])
            3'b010, 3'b011: branch_cond = ex_pkg::COND_NEVER;
            default:        branch_cond = ex_pkg::branch_cond_e'(inst[14:12]);
        endcase
    end

    ////////////////////
    // Start lines
    ////////////////////
    for (genvar i = 0; i < `EX_NUM_ALU; i++) begin : gen_alu_start
        assign alu_start[i] = issue_valid && (issue_fu_type == ex_pkg::FU_ALU)
                              && (issue_fu_index == `EX_FU_IDX_W'(i));
    end

    assign branch_start = issue_valid && (issue_fu_type == ex_pkg::FU_BRANCH);  // No index

endmodule

//--- hdl/alu_unit.sv
/* One integer ALU unit. done is high for the cycle after start.
   Result and tag hold until the next start */
`timescale 1ns/1ns
`include "ex_params.svh"

module alu_unit (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      start,
    input  ex_pkg::alu_func_e         func,
    input  logic [`EX_XLEN-1:0]       opa,
    input  logic [`EX_XLEN-1:0]       opb,
    input  logic [`EX_XLEN-1:0]       npc,
    input  logic [`EX_REG_IDX_W-1:0]  dest_reg_idx,
    input  logic [`EX_ROB_IDX_W-1:0]  rob_index,
    output logic                      done,
    output logic [`EX_XLEN-1:0]       result,
    output logic [`EX_XLEN-1:0]       done_npc,
    output logic [`EX_REG_IDX_W-1:0]  done_dest_reg_idx,
    output logic [`EX_ROB_IDX_W-1:0]  done_rob_index
);

    ex_pkg::alu_func_e        held_func;
    logic [`EX_XLEN-1:0]      held_opa;
    logic [`EX_XLEN-1:0]      held_opb;
    logic [`EX_SHAMT_W-1:0]   shamt;

    assign shamt = held_opb[`EX_SHAMT_W-1:0];

    always_ff @(posedge clock) begin
        if (reset) begin
            done <= 1'b0;
        end else begin
            done <= start;  // One-cycle pulse
        end
    end

    // Operands and tag captured on start
    always_ff @(posedge clock) begin
        if (start) begin
            held_func         <= func;
            held_opa          <= opa;
            held_opb          <= opb;
            done_npc          <= npc;
            done_dest_reg_idx <= dest_reg_idx;
            done_rob_index    <= rob_index;
        end
    end

    always_comb begin
        case (held_func)
            ex_pkg::ALU_ADD:  result = held_opa + held_opb;
            ex_pkg::ALU_SUB:  result = held_opa - held_opb;
            ex_pkg::ALU_SLT:  result = {{(`EX_XLEN-1){1'b0}}, $signed(held_opa) < $signed(held_opb)};
            ex_pkg::ALU_SLTU: result = {{(`EX_XLEN-1){1'b0}}, held_opa < held_opb};
            ex_pkg::ALU_AND:  result = held_opa & held_opb;
            ex_pkg::ALU_OR:   result = held_opa | held_opb;
            ex_pkg::ALU_XOR:  result = held_opa ^ held_opb;
            ex_pkg::ALU_SLL:  result = held_opa << shamt;
            ex_pkg::ALU_SRL:  result = held_opa >> shamt;
            ex_pkg::ALU_SRA:  result = $signed(held_opa) >>> shamt;  // Sign fill
            default:          result = '0;
        endcase
    end

endmodule

//--- hdl/branch_unit.sv
/* Branch unit. Result is the target, opa plus opb.
   take is valid with done and holds until the next start */
`timescale 1ns/1ns
`include "ex_params.svh"

module branch_unit (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      start,
    input  logic [`EX_XLEN-1:0]       opa,
    input  logic [`EX_XLEN-1:0]       opb,
    input  logic [`EX_XLEN-1:0]       rs1_value,
    input  logic [`EX_XLEN-1:0]       rs2_value,
    input  ex_pkg::branch_cond_e      cond,
    input  logic                      cond_branch,
    input  logic                      uncond_branch,
    input  logic [`EX_XLEN-1:0]       npc,
    input  logic [`EX_REG_IDX_W-1:0]  dest_reg_idx,
    input  logic [`EX_ROB_IDX_W-1:0]  rob_index,
    output logic                      done,
    output logic [`EX_XLEN-1:0]       result,
    output logic                      take,
    output logic [`EX_XLEN-1:0]       done_npc,
    output logic [`EX_REG_IDX_W-1:0]  done_dest_reg_idx,
    output logic [`EX_ROB_IDX_W-1:0]  done_rob_index
);

    logic [`EX_XLEN-1:0]   held_opa;
    logic [`EX_XLEN-1:0]   held_opb;
    logic [`EX_XLEN-1:0]   held_rs1;
    logic [`EX_XLEN-1:0]   held_rs2;
    ex_pkg::branch_cond_e  held_cond;
    logic                  held_cond_branch;
    logic                  held_uncond_branch;
    logic                  cond_true;

    always_ff @(posedge clock) begin
        if (reset) begin
            done <= 1'b0;
        end else begin
            done <= start;
        end
    end

    always_ff @(posedge clock) begin
        if (start) begin
            held_opa           <= opa;
            held_opb           <= opb;
            held_rs1           <= rs1_value;
            held_rs2           <= rs2_value;
            held_cond          <= cond;
            held_cond_branch   <= cond_branch;
            held_uncond_branch <= uncond_branch;
            done_npc           <= npc;
            done_dest_reg_idx  <= dest_reg_idx;
            done_rob_index     <= rob_index;
        end
    end

    assign result = held_opa + held_opb;  // Target address

    // Condition on the captured register values
    always_comb begin
        case (held_cond)
            ex_pkg::COND_EQ:  cond_true = held_rs1 == held_rs2;
            ex_pkg::COND_NE:  cond_true = held_rs1 != held_rs2;
            ex_pkg::COND_LT:  cond_true = $signed(held_rs1) < $signed(held_rs2);
            ex_pkg::COND_GE:  cond_true = $signed(held_rs1) >= $signed(held_rs2);
            ex_pkg::COND_LTU: cond_true = held_rs1 < held_rs2;
            ex_pkg::COND_GEU: cond_true = held_rs1 >= held_rs2;
            default:          cond_true = 1'b0;  // COND_NEVER
        endcase
    end

    assign take = held_uncond_branch || (held_cond_branch && cond_true);

endmodule

//--- hdl/ex_complete_arbiter.sv
/* Merges unit results onto one completion port, one per cycle.
   Fixed priority: ALU 0 first, branch last. No back-pressure */
`timescale 1ns/1ns
`include "ex_params.svh"

module ex_complete_arbiter (
    input  logic                      clock,
    input  logic                      reset,
    input  logic [`EX_NUM_ALU-1:0]    alu_done,
    input  logic [`EX_XLEN-1:0]       alu_result [`EX_NUM_ALU],
    input  logic [`EX_XLEN-1:0]       alu_npc [`EX_NUM_ALU],
    input  logic [`EX_REG_IDX_W-1:0]  alu_dest_reg_idx [`EX_NUM_ALU],
    input  logic [`EX_ROB_IDX_W-1:0]  alu_rob_index [`EX_NUM_ALU],
    input  logic                      branch_done,
    input  logic [`EX_XLEN-1:0]       branch_result,
    input  logic                      branch_take,
    input  logic [`EX_XLEN-1:0]       branch_npc,
    input  logic [`EX_REG_IDX_W-1:0]  branch_dest_reg_idx,
    input  logic [`EX_ROB_IDX_W-1:0]  branch_rob_index,
    output logic                      done_valid,
    output logic [`EX_XLEN-1:0]       done_result,
    output logic [`EX_XLEN-1:0]       done_npc,
    output logic                      done_take_branch,
    output logic [`EX_REG_IDX_W-1:0]  done_dest_reg_idx,
    output logic [`EX_ROB_IDX_W-1:0]  done_rob_index,
    output logic [`EX_NUM_ALU-1:0]    free_alu,
    output logic                      free_branch
);

    localparam int NUM_FU = `EX_NUM_ALU + 1;  // Branch is the top bit

    logic [NUM_FU-1:0]          pending;
    logic [NUM_FU-1:0]          candidates;
    logic [NUM_FU-1:0]          grant;
    logic [`EX_XLEN-1:0]        sel_result;
    logic [`EX_XLEN-1:0]        sel_npc;
    logic                       sel_take;
    logic [`EX_REG_IDX_W-1:0]   sel_dest_reg_idx;
    logic [`EX_ROB_IDX_W-1:0]   sel_rob_index;

    ////////////////////
    // Selection
    ////////////////////
    assign candidates = pending | {branch_done, alu_done};
    assign grant      = candidates & (~candidates + NUM_FU'(1));  // Lowest set bit wins

    always_comb begin
        sel_result       = branch_result;
        sel_npc          = branch_npc;
        sel_take         = branch_take;
        sel_dest_reg_idx = branch_dest_reg_idx;
        sel_rob_index    = branch_rob_index;
        for (int i = 0; i < `EX_NUM_ALU; i++) begin
            if (grant[i]) begin
                sel_result       = alu_result[i];
                sel_npc          = alu_npc[i];
                sel_take         = 1'b0;  // ALU never branches
                sel_dest_reg_idx = alu_dest_reg_idx[i];
                sel_rob_index    = alu_rob_index[i];
            end
        end
    end

    ////////////////////
    // Completion port
    ////////////////////
    always_ff @(posedge clock) begin
        if (reset) begin
            pending     <= '0;
            done_valid  <= 1'b0;
            free_alu    <= '0;
            free_branch <= 1'b0;
        end else begin
            pending     <= candidates & ~grant;  // Losers wait
            done_valid  <= |grant;
            free_alu    <= grant[`EX_NUM_ALU-1:0];
            free_branch <= grant[`EX_NUM_ALU];
        end
    end

    always_ff @(posedge clock) begin
        if (|grant) begin
            done_result       <= sel_result;
            done_npc          <= sel_npc;
            done_take_branch  <= sel_take;
            done_dest_reg_idx <= sel_dest_reg_idx;
            done_rob_index    <= sel_rob_index;
        end
    end

endmodule

//--- hdl/ex_stage.sv
/* Execute stage top: operand select, EX_NUM_ALU ALUs, one branch unit.
   A unit must not be reissued before its free pulse; this is not checked */
`timescale 1ns/1ns
`include "ex_params.svh"

module ex_stage (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      issue_valid,
    input  ex_pkg::fu_type_e          issue_fu_type,
    input  logic [`EX_FU_IDX_W-1:0]   issue_fu_index,
    input  ex_pkg::alu_func_e         alu_func,
    input  ex_pkg::opa_sel_e          opa_select,
    input  ex_pkg::opb_sel_e          opb_select,
    input  logic [31:0]               inst,
    input  logic [`EX_XLEN-1:0]       pc,
    input  logic [`EX_XLEN-1:0]       npc,
    input  logic [`EX_XLEN-1:0]       rs1_value,
    input  logic [`EX_XLEN-1:0]       rs2_value,
    input  logic [`EX_REG_IDX_W-1:0]  dest_reg_idx,
    input  logic [`EX_ROB_IDX_W-1:0]  rob_index,
    input  logic                      cond_branch,
    input  logic                      uncond_branch,
    output logic                      done_valid,
    output logic [`EX_XLEN-1:0]       done_result,
    output logic [`EX_XLEN-1:0]       done_npc,
    output logic                      done_take_branch,
    output logic [`EX_REG_IDX_W-1:0]  done_dest_reg_idx,
    output logic [`EX_ROB_IDX_W-1:0]  done_rob_index,
    output logic [`EX_NUM_ALU-1:0]    free_alu,
    output logic                      free_branch
);

    logic [`EX_XLEN-1:0]       opa;
    logic [`EX_XLEN-1:0]       opb;
    ex_pkg::branch_cond_e      branch_cond;
    logic [`EX_NUM_ALU-1:0]    alu_start;
    logic                      branch_start;

    // Per-unit results
    logic [`EX_NUM_ALU-1:0]    alu_done;
    logic [`EX_XLEN-1:0]       alu_result [`EX_NUM_ALU];
    logic [`EX_XLEN-1:0]       alu_npc [`EX_NUM_ALU];
    logic [`EX_REG_IDX_W-1:0]  alu_dest_reg_idx [`EX_NUM_ALU];
    logic [`EX_ROB_IDX_W-1:0]  alu_rob_index [`EX_NUM_ALU];
    logic                      branch_done;
    logic [`EX_XLEN-1:0]       branch_result;
    logic                      branch_take;
    logic [`EX_XLEN-1:0]       branch_npc;
    logic [`EX_REG_IDX_W-1:0]  branch_dest_reg_idx;
    logic [`EX_ROB_IDX_W-1:0]  branch_rob_index;

    ex_operand_select ex_operand_select_inst (
        .issue_valid(issue_valid), .issue_fu_type(issue_fu_type),
        .issue_fu_index(issue_fu_index), .opa_select(opa_select),
        .opb_select(opb_select), .inst(inst), .pc(pc), .npc(npc),
        .rs1_value(rs1_value), .rs2_value(rs2_value), .opa(opa), .opb(opb),
        .branch_cond(branch_cond), .alu_start(alu_start), .branch_start(branch_start)
    );

    for (genvar i = 0; i < `EX_NUM_ALU; i++) begin : gen_alu
        alu_unit alu_unit_inst (
            .clock(clock), .reset(reset), .start(alu_start[i]), .func(alu_func),
            .opa(opa), .opb(opb), .npc(npc), .dest_reg_idx(dest_reg_idx),
            .rob_index(rob_index), .done(alu_done[i]), .result(alu_result[i]),
            .done_npc(alu_npc[i]), .done_dest_reg_idx(alu_dest_reg_idx[i]),
            .done_rob_index(alu_rob_index[i])
        );
    end

    branch_unit branch_unit_inst (
        .clock(clock), .reset(reset), .start(branch_start), .opa(opa), .opb(opb),
        .rs1_value(rs1_value), .rs2_value(rs2_value), .cond(branch_cond),
        .cond_branch(cond_branch), .uncond_branch(uncond_branch), .npc(npc),
        .dest_reg_idx(dest_reg_idx), .rob_index(rob_index), .done(branch_done),
        .result(branch_result), .take(branch_take), .done_npc(branch_npc),
        .done_dest_reg_idx(branch_dest_reg_idx), .done_rob_index(branch_rob_index)
    );

    ex_complete_arbiter ex_complete_arbiter_inst (
        .clock(clock), .reset(reset), .alu_done(alu_done), .alu_result(alu_result),
        .alu_npc(alu_npc), .alu_dest_reg_idx(alu_dest_reg_idx),
        .alu_rob_index(alu_rob_index), .branch_done(branch_done),
        .branch_result(branch_result), .branch_take(branch_take),
        .branch_npc(branch_npc), .branch_dest_reg_idx(branch_dest_reg_idx),
        .branch_rob_index(branch_rob_index), .done_valid(done_valid),
        .done_result(done_result), .done_npc(done_npc),
        .done_take_branch(done_take_branch), .done_dest_reg_idx(done_dest_reg_idx),
        .done_rob_index(done_rob_index), .free_alu(free_alu), .free_branch(free_branch)
    );

endmodule

//--- tb/ex_stage_tb.sv
/* Directed tests for the execute stage, inputs driven on the falling edge.
   One issue per cycle at most; each unit waits for its free pulse before reuse */
`timescale 1ns/1ns
`include "ex_params.svh"

module ex_stage_tb;

    localparam int MAX_CYCLES = 1500;  // About 90 issues under 8 cycles each, plus margin

    logic clock, reset, issue_valid, cond_branch, uncond_branch;
    ex_pkg::fu_type_e issue_fu_type;
    logic [`EX_FU_IDX_W-1:0] issue_fu_index;
    ex_pkg::alu_func_e alu_func;
    ex_pkg::opa_sel_e opa_select;
    ex_pkg::opb_sel_e opb_select;
    logic [31:0] inst;
    logic [`EX_XLEN-1:0] pc, npc, rs1_value, rs2_value;
    logic [`EX_REG_IDX_W-1:0] dest_reg_idx;
    logic [`EX_ROB_IDX_W-1:0] rob_index;
    logic done_valid, done_take_branch, free_branch;
    logic [`EX_XLEN-1:0] done_result, done_npc;
    logic [`EX_REG_IDX_W-1:0] done_dest_reg_idx;
    logic [`EX_ROB_IDX_W-1:0] done_rob_index;
    logic [`EX_NUM_ALU-1:0] free_alu;

    integer seed = 92;
    int error_count = 0;
    int test_count = 0;
    int cycle_count = 0;

    ex_stage ex_stage_inst (.*);

    always #5 clock = ~clock;

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: tests still running after %0d cycles", cycle_count);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    ////////////////////
    // Reference rules
    ////////////////////
    function automatic logic [`EX_XLEN-1:0] alu_model(ex_pkg::alu_func_e f,
            logic [31:0] a, logic [31:0] b);
        logic [4:0] sh;
        sh = b[4:0];  // RV32 uses shamt[4:0]
        case (f)
            ex_pkg::ALU_ADD:  return a + b;
            ex_pkg::ALU_SUB:  return a - b;
            ex_pkg::ALU_SLT:  return (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, a < b};
            ex_pkg::ALU_SLTU: return {31'b0, a < b};
            ex_pkg::ALU_AND:  return a & b;
            ex_pkg::ALU_OR:   return a | b;
            ex_pkg::ALU_XOR:  return a ^ b;
            ex_pkg::ALU_SLL:  return a << sh;
            ex_pkg::ALU_SRL:  return a >> sh;
            ex_pkg::ALU_SRA:  return (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'h0);
            default:          return '0;
        endcase
    endfunction

    function automatic logic [`EX_XLEN-1:0] imm_of(ex_pkg::opb_sel_e sel, logic [31:0] w);
        logic [11:0] i12;
        logic [11:0] s12;
        logic [12:0] b13;
        logic [20:0] j21;
        i12 = w[31:20];
        s12 = {w[31:25], w[11:7]};
        b13 = {w[31], w[7], w[30:25], w[11:8], 1'b0};
        j21 = {w[31], w[19:12], w[20], w[30:21], 1'b0};
        case (sel)
            ex_pkg::OPB_I_IMM: return 32'($signed(i12));
            ex_pkg::OPB_S_IMM: return 32'($signed(s12));
            ex_pkg::OPB_B_IMM: return 32'($signed(b13));
            ex_pkg::OPB_U_IMM: return {w[31:12], 12'h000};
            ex_pkg::OPB_J_IMM: return 32'($signed(j21));
            default:           return '0;
        endcase
    endfunction

    function automatic logic [`EX_XLEN-1:0] opa_source(ex_pkg::opa_sel_e sel);
        case (sel)
            ex_pkg::OPA_RS1: return rs1_value;
            ex_pkg::OPA_NPC: return npc;
            ex_pkg::OPA_PC:  return pc;
            default:         return '0;
        endcase
    endfunction

    // Branch funct3 rule, codes 2 and 3 never hold
    function automatic logic cond_holds(logic [2:0] f3, logic [31:0] a, logic [31:0] b);
        case (f3)
            3'd0:    return a == b;
            3'd1:    return a != b;
            3'd4:    return $signed(a) < $signed(b);
            3'd5:    return !($signed(a) < $signed(b));
            3'd6:    return a < b;
            3'd7:    return !(a < b);
            default: return 1'b0;
        endcase
    endfunction

    ////////////////////
    // Compare tasks
    ////////////////////
    task automatic check_word(input string what, input logic [`EX_XLEN-1:0] got,
            input logic [`EX_XLEN-1:0] exp);
        if (got !== exp) begin
            error_count++;
            $display("[FAIL] %0t %s: got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            error_count++;
            $display("[FAIL] %0t %s: got %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_reg_idx(input string what, input logic [`EX_REG_IDX_W-1:0] got,
            input logic [`EX_REG_IDX_W-1:0] exp);
        if (got !== exp) begin
            error_count++;
            $display("[FAIL] %0t %s: got %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_rob_idx(input string what, input logic [`EX_ROB_IDX_W-1:0] got,
            input logic [`EX_ROB_IDX_W-1:0] exp);
        if (got !== exp) begin
            error_count++;
            $display("[FAIL] %0t %s: got %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    ////////////////////
    // Helpers
    ////////////////////
    task automatic set_random_tag();
        dest_reg_idx = 5'($random(seed));
        rob_index    = 4'($random(seed));
        pc           = $random(seed);
        pc[1:0]      = 2'b00;
        npc          = pc + 32'd4;
    endtask

    task automatic expect_completion(input logic [`EX_XLEN-1:0] result, input logic take,
            input logic [`EX_REG_IDX_W-1:0] dest, input logic [`EX_ROB_IDX_W-1:0] rob,
            input logic [`EX_XLEN-1:0] next_pc, input logic [`EX_NUM_ALU-1:0] alu_free,
            input logic branch_free);
        check_bit("done_valid", done_valid, 1'b1);
        check_word("done_result", done_result, result);
        check_word("done_npc", done_npc, next_pc);
        check_bit("done_take_branch", done_take_branch, take);
        check_reg_idx("done_dest_reg_idx", done_dest_reg_idx, dest);
        check_rob_idx("done_rob_index", done_rob_index, rob);
        for (int i = 0; i < `EX_NUM_ALU; i++) begin
            check_bit($sformatf("free_alu[%0d]", i), free_alu[i], alu_free[i]);
        end
        check_bit("free_branch", free_branch, branch_free);
    endtask

    // Issue one instruction, wait for its completion and check it
    task automatic run_issue(input ex_pkg::fu_type_e fu, input int idx,
            input logic [`EX_XLEN-1:0] result, input logic take);
        int latency;
        issue_fu_type  = fu;
        issue_fu_index = `EX_FU_IDX_W'(idx);
        issue_valid    = 1'b1;
        @(negedge clock);
        issue_valid = 1'b0;
        latency = 1;
        while (!done_valid && latency < 8) begin
            @(negedge clock);
            latency++;
        end
        if (!done_valid) begin
            error_count++;
            $display("No completion within %0d cycles of the issue, time %0t", latency, $time);
        end else if (latency != 2) begin
            error_count++;
            $display("[FAIL] %0t completion after %0d cycles, expected 2", $time, latency);
        end
        if (fu == ex_pkg::FU_BRANCH) begin
            expect_completion(result, take, dest_reg_idx, rob_index, npc, '0, 1'b1);
        end else begin
            expect_completion(result, 1'b0, dest_reg_idx, rob_index, npc,
                              `EX_NUM_ALU'(1 << idx), 1'b0);
        end
        @(negedge clock);  // Back to idle
    endtask

    task automatic check_quiet(input int cycles);
        repeat (cycles) begin
            check_bit("done_valid", done_valid, 1'b0);
            check_word("free bits", {28'b0, free_branch, free_alu}, '0);
            @(negedge clock);
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        test_count++;
        $display("Test %-16s finished with %0d errors", name, error_count - errors_before);
    endtask

    ////////////////////
    // Tests
    ////////////////////
    task automatic test_reset();
        int errors_before;
        errors_before = error_count;
        check_quiet(6);
        finish_test("reset", errors_before);
    endtask

    task automatic test_alu_ops();
        int errors_before;
        errors_before = error_count;
        opa_select = ex_pkg::OPA_RS1;
        opb_select = ex_pkg::OPB_RS2;
        for (int f = 0; f < 10; f++) begin
            for (int u = 0; u < `EX_NUM_ALU; u++) begin
                set_random_tag();
                rs1_value = $random(seed);
                rs2_value = $random(seed);
                alu_func  = ex_pkg::alu_func_e'(4'(f));
                run_issue(ex_pkg::FU_ALU, u, alu_model(alu_func, rs1_value, rs2_value), 1'b0);
            end
        end
        finish_test("alu_ops", errors_before);
    endtask

    task automatic test_operand_select();
        int errors_before;
        logic [31:0] words [5];
        errors_before = error_count;
        words = '{32'hfff0_0513, 32'h8012_a023, 32'hfe20_9ce3, 32'h1234_5537, 32'h8000_00ef};
        alu_func = ex_pkg::ALU_ADD;
        for (int a = 0; a < 4; a++) begin  // Each operand A source
            set_random_tag();
            rs1_value  = $random(seed);
            rs2_value  = $random(seed);
            opa_select = ex_pkg::opa_sel_e'(2'(a));
            opb_select = ex_pkg::OPB_RS2;
            run_issue(ex_pkg::FU_ALU, a % `EX_NUM_ALU, opa_source(opa_select) + rs2_value, 1'b0);
        end
        for (int k = 0; k < 5; k++) begin  // I, S, B, U, J in enum order
            set_random_tag();
            rs1_value  = $random(seed);
            inst       = words[k];
            opa_select = ex_pkg::OPA_RS1;
            opb_select = ex_pkg::opb_sel_e'(3'(k + 1));
            run_issue(ex_pkg::FU_ALU, k % `EX_NUM_ALU, rs1_value + imm_of(opb_select, inst),
                      1'b0);
        end
        finish_test("operand_select", errors_before);
    endtask

    task automatic test_branch();
        int errors_before;
        logic take;
        logic [31:0] a_vals [3];
        logic [31:0] b_vals [3];
        errors_before = error_count;
        // Equal, signed-less, unsigned-less with the sign bits opposite
        a_vals = '{32'h1234_5678, 32'h8000_0010, 32'h0000_0010};
        b_vals = '{32'h1234_5678, 32'h0000_0010, 32'h8000_0010};
        opa_select = ex_pkg::OPA_PC;
        opb_select = ex_pkg::OPB_B_IMM;
        for (int f3 = 0; f3 < 8; f3++) begin
            for (int p = 0; p < 3; p++) begin
                for (int kind = 0; kind < 2; kind++) begin
                    set_random_tag();
                    inst          = $random(seed);
                    inst[14:12]   = 3'(f3);
                    inst[6:0]     = 7'h63;
                    rs1_value     = a_vals[p];
                    rs2_value     = b_vals[p];
                    cond_branch   = (kind == 0);
                    uncond_branch = (kind == 1);
                    take = uncond_branch || (cond_branch && cond_holds(3'(f3), rs1_value,
                                                                      rs2_value));
                    run_issue(ex_pkg::FU_BRANCH, 0, pc + imm_of(ex_pkg::OPB_B_IMM, inst), take);
                end
            end
        end
        cond_branch   = 1'b0;
        uncond_branch = 1'b0;
        finish_test("branch", errors_before);
    endtask

    // ALU 0, 1, 2 then branch on back-to-back cycles
    task automatic test_contention();
        int errors_before;
        logic [`EX_XLEN-1:0] exp_result [4];
        logic [`EX_XLEN-1:0] exp_npc [4];
        logic [`EX_REG_IDX_W-1:0] exp_dest [4];
        logic [`EX_ROB_IDX_W-1:0] exp_rob [4];
        errors_before = error_count;
        for (int s = 0; s < 7; s++) begin
            if (s >= 2 && s < 6) begin
                expect_completion(exp_result[s-2], s == 5, exp_dest[s-2], exp_rob[s-2],
                                  exp_npc[s-2], `EX_NUM_ALU'(1 << (s - 2)), s == 5);
            end else begin
                check_bit("done_valid", done_valid, 1'b0);
            end
            if (s < 4) begin
                set_random_tag();
                rs1_value      = $random(seed);
                rs2_value      = $random(seed);
                opa_select     = ex_pkg::OPA_RS1;
                opb_select     = ex_pkg::OPB_RS2;
                alu_func       = ex_pkg::alu_func_e'(4'(3 * s));
                issue_fu_type  = ex_pkg::FU_ALU;
                issue_fu_index = `EX_FU_IDX_W'(s);
                exp_result[s]  = alu_model(alu_func, rs1_value, rs2_value);
                if (s == 3) begin  // BEQ on equal registers
                    issue_fu_type = ex_pkg::FU_BRANCH;
                    rs2_value     = rs1_value;
                    inst          = $random(seed);
                    inst[14:12]   = 3'b000;
                    inst[6:0]     = 7'h63;
                    opa_select    = ex_pkg::OPA_PC;
                    opb_select    = ex_pkg::OPB_B_IMM;
                    cond_branch   = 1'b1;
                    exp_result[s] = pc + imm_of(ex_pkg::OPB_B_IMM, inst);
                end
                exp_npc[s]  = npc;
                exp_dest[s] = dest_reg_idx;
                exp_rob[s]  = rob_index;
                issue_valid = 1'b1;
            end else begin
                issue_valid = 1'b0;
            end
            @(negedge clock);
        end
        cond_branch = 1'b0;
        finish_test("contention", errors_before);
    endtask

    task automatic test_ignored_issues();
        int errors_before;
        errors_before = error_count;
        set_random_tag();
        issue_fu_type  = ex_pkg::FU_ALU;
        issue_fu_index = '0;
        @(negedge clock);  // Valid stays low
        check_quiet(4);
        issue_fu_index = `EX_FU_IDX_W'(`EX_NUM_ALU);  // Past the last ALU
        issue_valid    = 1'b1;
        @(negedge clock);
        issue_valid = 1'b0;
        check_quiet(4);
        finish_test("ignored_issues", errors_before);
    endtask

    initial begin
        clock          = 1'b0;
        reset          = 1'b1;
        issue_valid    = 1'b0;
        issue_fu_type  = ex_pkg::FU_ALU;
        issue_fu_index = '0;
        alu_func       = ex_pkg::ALU_ADD;
        opa_select     = ex_pkg::OPA_RS1;
        opb_select     = ex_pkg::OPB_RS2;
        inst           = '0;
        pc             = '0;
        npc            = '0;
        rs1_value      = '0;
        rs2_value      = '0;
        dest_reg_idx   = '0;
        rob_index      = '0;
        cond_branch    = 1'b0;
        uncond_branch  = 1'b0;
        repeat (5) @(negedge clock);
        reset = 1'b0;
        test_reset();
        test_alu_ops();
        test_operand_select();
        test_branch();
        test_contention();
        test_ignored_issues();
        $display("Tests run: %0d, errors: %0d", test_count, error_count);
        if (error_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- build.f
+incdir+include
hdl/ex_pkg.sv
hdl/ex_operand_select.sv
hdl/alu_unit.sv
hdl/branch_unit.sv
hdl/ex_complete_arbiter.sv
hdl/ex_stage.sv
tb/ex_stage_tb.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the execute stage testbench with Verilator.
# Exit status is 0 only when the simulation log holds the pass message.
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing -j 0 --top-module ex_stage_tb -f build.f -o ex_stage_sim \
    > build.log 2>&1 \
    && ./obj_dir/ex_stage_sim > sim.log 2>&1 \
    || { cat build.log; echo "Compile or simulation error"; }
cat sim.log 2>/dev/null
grep -qx "PASS: all tests" sim.log && exit 0 || exit 1
